//--- hw/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define RN_ARCH_REGS   32
`define RN_ARCH_W      5

// physical register file
`define RN_PHYS_REGS   64
`define RN_PHYS_W      6

`define RN_CKPTS       4
`define RN_CKPT_W      2
`define RN_FREE_PTR_W  7    // tag index plus wrap bit

`endif

//--- hw/rename_pkg.sv
`include "rename_config.svh"

package rename_pkg;

    // rv32i major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [`RN_ARCH_W-1:0]  rd;
        logic [`RN_ARCH_W-1:0]  rs1;
        logic [`RN_ARCH_W-1:0]  rs2;
    } rename_req_t;

    typedef struct packed {
        logic [`RN_PHYS_W-1:0]  prs1;
        logic                   prs1_used;
        logic [`RN_PHYS_W-1:0]  prs2;
        logic                   prs2_used;
        logic [`RN_PHYS_W-1:0]  prd;
        logic                   prd_used;
        logic [`RN_PHYS_W-1:0]  old_prd;    // freed by the rob at commit
    } rename_result_t;

    typedef logic [`RN_ARCH_REGS-1:0][`RN_PHYS_W-1:0] map_image_t;

    typedef struct packed {
        map_image_t                 map_img;
        logic [`RN_FREE_PTR_W-1:0]  head;
    } checkpoint_t;

    // xN on pN, the state out of reset
    function automatic map_image_t identity_map();
        map_image_t img;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            img[i] = `RN_PHYS_W'(i);
        end
        return img;
    endfunction

endpackage

//--- hw/rename_ctrl.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module rename_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rename_valid,
    input  rename_pkg::rename_req_t   req,
    input  logic                      save,
    input  logic                      restore,
    input  logic                      commit_valid,
    input  logic                      empty,
    input  logic [`RN_PHYS_W-1:0]     head_tag,
    input  logic [`RN_PHYS_W-1:0]     rd_tag1,
    input  logic [`RN_PHYS_W-1:0]     rd_tag2,
    input  logic [`RN_PHYS_W-1:0]     old_tag,
    output logic [`RN_ARCH_W-1:0]     rd_addr1,
    output logic [`RN_ARCH_W-1:0]     rd_addr2,
    output logic                      wr_en,
    output logic [`RN_ARCH_W-1:0]     wr_addr,
    output logic [`RN_PHYS_W-1:0]     wr_tag,
    output logic                      pop,
    output logic                      push,
    output logic                      load_ckpt,
    output logic                      result_valid,
    output rename_pkg::rename_result_t result,
    output logic                      stall
);
    import rename_pkg::*;

    logic uses_rs1;
    logic uses_rs2;
    logic has_rd;
    logic accept;
    logic alloc;

    always_comb begin
        case (req.opcode)
            OP_JALR, OP_LOAD, OP_IMM: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b0;
            end
            OP_LUI, OP_AUIPC, OP_JAL: begin
                uses_rs1 = 1'b0;
                uses_rs2 = 1'b0;
            end
            default: begin      // r-type, branch, store
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
        endcase
    end

    assign has_rd = (req.opcode != OP_BRANCH) && (req.opcode != OP_STORE) && (req.rd != '0);

    // restore squashes a same-cycle rename and empty drops only allocating ones
    assign accept = rename_valid && !restore && !(has_rd && empty);
    assign alloc  = accept && has_rd;

    assign rd_addr1  = req.rs1;
    assign rd_addr2  = req.rs2;
    assign wr_en     = alloc;
    assign wr_addr   = req.rd;     // also the old mapping lookup
    assign wr_tag    = head_tag;
    assign pop       = alloc;
    assign push      = commit_valid;
    assign load_ckpt = restore;
    assign stall     = empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        result.prs1      <= uses_rs1 ? rd_tag1 : '0;
        result.prs1_used <= uses_rs1;
        result.prs2      <= uses_rs2 ? rd_tag2 : '0;
        result.prs2_used <= uses_rs2;
        result.prd       <= alloc ? head_tag : '0;
        result.prd_used  <= alloc;
        result.old_prd   <= alloc ? old_tag : '0;
    end

endmodule

//--- hw/map_table.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module map_table (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`RN_ARCH_W-1:0]   rd_addr1,
    input  logic [`RN_ARCH_W-1:0]   rd_addr2,
    input  logic [`RN_ARCH_W-1:0]   old_addr,
    input  logic                    wr_en,
    input  logic [`RN_ARCH_W-1:0]   wr_addr,
    input  logic [`RN_PHYS_W-1:0]   wr_tag,
    input  logic                    load,
    input  rename_pkg::map_image_t  load_image,
    output logic [`RN_PHYS_W-1:0]   rd_tag1,
    output logic [`RN_PHYS_W-1:0]   rd_tag2,
    output logic [`RN_PHYS_W-1:0]   old_tag,
    output rename_pkg::map_image_t  image
);
    import rename_pkg::*;

    map_image_t map_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            map_q <= identity_map();
        end else if (load) begin
            map_q <= load_image;        // recovery wins over the new mapping
        end else if (wr_en) begin
            map_q[wr_addr] <= wr_tag;
        end
    end

    // reads see the table as of the last edge
    assign rd_tag1 = map_q[rd_addr1];
    assign rd_tag2 = map_q[rd_addr2];
    assign old_tag = map_q[old_addr];
    assign image   = map_q;

endmodule

//--- hw/free_list.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module free_list (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pop,
    input  logic                        push,
    input  logic [`RN_PHYS_W-1:0]       push_tag,
    input  logic                        restore,
    input  logic [`RN_FREE_PTR_W-1:0]   restore_ptr,
    output logic [`RN_PHYS_W-1:0]       head_tag,
    output logic                        empty,
    output logic [`RN_FREE_PTR_W-1:0]   head_ptr
);

    logic [`RN_PHYS_W-1:0]      mem [`RN_PHYS_REGS];
    logic [`RN_FREE_PTR_W-1:0]  head;
    logic [`RN_FREE_PTR_W-1:0]  tail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head <= '0;
            tail <= `RN_FREE_PTR_W'(`RN_ARCH_REGS);   // upper half starts free
        end else begin
            if (restore) begin
                head <= restore_ptr;    // hands back the tags taken since the save
            end else if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // slot i holds tag 32+i out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                mem[i] <= `RN_PHYS_W'(i + `RN_ARCH_REGS);
            end
        end else if (push) begin
            mem[tail[`RN_PHYS_W-1:0]] <= push_tag;
        end
    end

    assign head_tag = mem[head[`RN_PHYS_W-1:0]];
    assign empty    = (head == tail);     // wrap bits equal too
    assign head_ptr = head;

endmodule

//--- hw/checkpoint_store.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module checkpoint_store (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    save,
    input  logic [`RN_CKPT_W-1:0]   save_page,
    input  rename_pkg::checkpoint_t save_data,
    input  logic [`RN_CKPT_W-1:0]   restore_page,
    output rename_pkg::checkpoint_t restore_data
);
    import rename_pkg::*;

    checkpoint_t slots [`RN_CKPTS];

    // every page starts as the reset state of the table and free list
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RN_CKPTS; i++) begin
                slots[i].map_img <= identity_map();
                slots[i].head    <= '0;
            end
        end else if (save) begin
            slots[save_page] <= save_data;
        end
    end

    assign restore_data = slots[restore_page];  // old contents on a same-page save

endmodule

//--- hw/rename_top.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module rename_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rename_valid,
    input  rename_pkg::rename_req_t     req,
    input  logic                        save,
    input  logic [`RN_CKPT_W-1:0]       save_page,
    input  logic                        restore,
    input  logic [`RN_CKPT_W-1:0]       restore_page,
    input  logic                        commit_valid,
    input  logic [`RN_PHYS_W-1:0]       commit_tag,
    output logic                        result_valid,
    output rename_pkg::rename_result_t  result,
    output logic                        stall
);
    import rename_pkg::*;

    logic [`RN_ARCH_W-1:0]      rd_addr1;
    logic [`RN_ARCH_W-1:0]      rd_addr2;
    logic [`RN_ARCH_W-1:0]      wr_addr;
    logic [`RN_PHYS_W-1:0]      rd_tag1;
    logic [`RN_PHYS_W-1:0]      rd_tag2;
    logic [`RN_PHYS_W-1:0]      old_tag;
    logic [`RN_PHYS_W-1:0]      wr_tag;
    logic [`RN_PHYS_W-1:0]      head_tag;
    logic [`RN_FREE_PTR_W-1:0]  head_ptr;
    logic                       wr_en;
    logic                       pop;
    logic                       push;
    logic                       load_ckpt;
    logic                       empty;
    map_image_t                 image;
    checkpoint_t                save_data;
    checkpoint_t                restore_data;

    assign save_data.map_img = image;
    assign save_data.head    = head_ptr;

    rename_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .rename_valid (rename_valid),
        .req          (req),
        .save         (save),
        .restore      (restore),
        .commit_valid (commit_valid),
        .empty        (empty),
        .head_tag     (head_tag),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .old_tag      (old_tag),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_tag       (wr_tag),
        .pop          (pop),
        .push         (push),
        .load_ckpt    (load_ckpt),
        .result_valid (result_valid),
        .result       (result),
        .stall        (stall)
    );

    map_table u_map (
        .clk        (clk),
        .reset      (reset),
        .rd_addr1   (rd_addr1),
        .rd_addr2   (rd_addr2),
        .old_addr   (wr_addr),      // rd lookup for old_prd
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_tag     (wr_tag),
        .load       (load_ckpt),
        .load_image (restore_data.map_img),
        .rd_tag1    (rd_tag1),
        .rd_tag2    (rd_tag2),
        .old_tag    (old_tag),
        .image      (image)
    );

    free_list u_free (
        .clk         (clk),
        .reset       (reset),
        .pop         (pop),
        .push        (push),
        .push_tag    (commit_tag),
        .restore     (load_ckpt),
        .restore_ptr (restore_data.head),
        .head_tag    (head_tag),
        .empty       (empty),
        .head_ptr    (head_ptr)
    );

    checkpoint_store u_ckpt (
        .clk          (clk),
        .reset        (reset),
        .save         (save),
        .save_page    (save_page),
        .save_data    (save_data),
        .restore_page (restore_page),
        .restore_data (restore_data)
    );

endmodule

//--- testbench/rename_tb.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int STIM_CYCLES  = 2000;
    localparam int QUIET_CYCLES = 150;      // commits withheld so the free list drains
    localparam int CYCLE_LIMIT  = STIM_CYCLES + STIM_CYCLES / 2;
    // rv32i mix with the alu classes doubled for more r-type and op-imm
    localparam logic [11:0][6:0] OPS = {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_IMM, OP_IMM, 7'b0110011, 7'b0110011, 7'b1110011};

    logic                       clk;
    logic                       reset;
    logic                       rename_valid;
    rename_req_t                req;
    logic                       save;
    logic [`RN_CKPT_W-1:0]      save_page;
    logic                       restore;
    logic [`RN_CKPT_W-1:0]      restore_page;
    logic                       commit_valid;
    logic [`RN_PHYS_W-1:0]      commit_tag;
    logic                       result_valid;
    rename_result_t             result;
    logic                       stall;

    map_image_t                 m_map;
    map_image_t                 ck_map [`RN_CKPTS];
    logic [`RN_PHYS_W-1:0]      m_fifo [`RN_PHYS_REGS];
    logic [`RN_FREE_PTR_W-1:0]  m_head;
    logic [`RN_FREE_PTR_W-1:0]  m_tail;
    logic [`RN_FREE_PTR_W-1:0]  ck_head [`RN_CKPTS];
    logic [`RN_PHYS_REGS-1:0]   outst;          // displaced tags not yet committed
    logic [`RN_PHYS_REGS-1:0]   outst_snap;
    logic                       exp_valid;
    rename_result_t             exp_res;
    logic [31:0]                rng;
    logic                       live;           // a saved page waits for its restore
    logic [`RN_CKPT_W-1:0]      live_page;
    logic [`RN_ARCH_W-1:0]      last_rd;
    int                         errors;
    int                         stall_cycles;
    int                         restores;
    int                         watchdog;

    rename_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // {rs1 used, rs2 used}
    function automatic logic [1:0] source_use(input logic [6:0] op);
        case (op)
            OP_JALR, OP_LOAD, OP_IMM: return 2'b10;
            OP_LUI, OP_AUIPC, OP_JAL: return 2'b00;
            default:                  return 2'b11;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] gotv);
        if (gotv !== expv) begin
            errors++;
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, expv, gotv);
        end
    endtask

    task automatic check_outputs();
        compare_field("stall", m_head == m_tail, stall);
        compare_field("result_valid", exp_valid, result_valid);
        if (exp_valid) begin
            compare_field("result.prs1", exp_res.prs1, result.prs1);
            compare_field("result.prs1_used", exp_res.prs1_used, result.prs1_used);
            compare_field("result.prs2", exp_res.prs2, result.prs2);
            compare_field("result.prs2_used", exp_res.prs2_used, result.prs2_used);
            compare_field("result.prd", exp_res.prd, result.prd);
            compare_field("result.prd_used", exp_res.prd_used, result.prd_used);
            compare_field("result.old_prd", exp_res.old_prd, result.old_prd);
        end
        if (stall) begin
            stall_cycles++;
        end
    endtask

    // applies the inputs the DUT samples at this edge
    task automatic model_step();
        logic [1:0] src;
        logic       dest;
        logic       accept;
        logic       alloc;
        src    = source_use(req.opcode);
        dest   = req.opcode != OP_BRANCH && req.opcode != OP_STORE && req.rd != '0;
        accept = rename_valid && !restore && !(dest && m_head == m_tail);
        alloc  = accept && dest;
        exp_valid         = accept;
        exp_res.prs1      = src[1] ? m_map[req.rs1] : '0;
        exp_res.prs1_used = src[1];
        exp_res.prs2      = src[0] ? m_map[req.rs2] : '0;
        exp_res.prs2_used = src[0];
        exp_res.prd       = alloc ? m_fifo[m_head[`RN_PHYS_W-1:0]] : '0;
        exp_res.prd_used  = alloc;
        exp_res.old_prd   = alloc ? m_map[req.rd] : '0;
        if (save) begin
            ck_map[save_page]  = m_map;     // taken before this edge's rename
            ck_head[save_page] = m_head;
            outst_snap         = outst;
        end
        if (restore) begin
            m_map  = ck_map[restore_page];
            m_head = ck_head[restore_page];
            outst  = outst_snap;
            restores++;
        end else if (alloc) begin
            outst[m_map[req.rd]] = 1'b1;
            m_map[req.rd]        = exp_res.prd;
            m_head++;
        end
        if (commit_valid) begin
            m_fifo[m_tail[`RN_PHYS_W-1:0]] = commit_tag;
            m_tail++;
        end
    endtask

    task automatic drive_next(input int cyc);
        rename_req_t            nr;
        logic [31:0]            r;
        logic [`RN_PHYS_W-1:0]  idx;
        logic                   found;
        rng = xorshift32(rng);
        r   = rng;
        nr.opcode = OPS[r[3:0] % 12];
        nr.rd     = (r[6:4] == 3'd0) ? '0 : r[11:7];          // extra x0 writes
        nr.rs1    = (r[13:12] == 2'd0) ? last_rd : r[18:14];  // dependent on last rd
        nr.rs2    = r[23:19];
        last_rd   = nr.rd;
        rename_valid <= (r[27:24] != 4'd0);
        req          <= nr;
        save         <= 1'b0;
        restore      <= 1'b0;
        commit_valid <= 1'b0;
        rng = xorshift32(rng);
        r   = rng;
        if (cyc >= QUIET_CYCLES && live && r[1:0] == 2'd0) begin
            restore      <= 1'b1;
            restore_page <= live_page;
            live = 1'b0;
        end else if (cyc >= QUIET_CYCLES && !live && r[5:2] == 4'd0) begin
            save      <= 1'b1;
            save_page <= r[7:6];
            live_page = r[7:6];
            live      = 1'b1;
        end else if (cyc >= QUIET_CYCLES && !live) begin
            found = 1'b0;
            for (int k = 0; k < `RN_PHYS_REGS; k++) begin
                idx = r[13:8] + `RN_PHYS_W'(k);     // first displaced tag from a random start
                if (!found && outst[idx]) begin
                    found        = 1'b1;
                    outst[idx]   = 1'b0;
                    commit_valid <= 1'b1;
                    commit_tag   <= idx;
                end
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        rename_valid = 1'b0;
        req          = '0;
        save         = 1'b0;
        save_page    = '0;
        restore      = 1'b0;
        restore_page = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        rng          = 32'h4475_81c3;
        live         = 1'b0;
        live_page    = '0;
        last_rd      = '0;
        errors       = 0;
        stall_cycles = 0;
        restores     = 0;
        exp_valid    = 1'b0;
        exp_res      = '0;
        outst        = '0;
        outst_snap   = '0;
        m_head       = '0;
        m_tail       = `RN_FREE_PTR_W'(`RN_ARCH_REGS);
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            m_map[i] = `RN_PHYS_W'(i);      // xN on pN
        end
        for (int i = 0; i < `RN_PHYS_REGS; i++) begin
            m_fifo[i] = `RN_PHYS_W'(i + `RN_ARCH_REGS);
        end
        for (int i = 0; i < `RN_CKPTS; i++) begin
            ck_map[i]  = m_map;
            ck_head[i] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            model_step();
            drive_next(cyc);
        end
        @(negedge clk);
        check_outputs();
        if (stall_cycles == 0) begin
            errors++;
            $display("stall never went high although commits were withheld");
        end
        if (restores == 0) begin
            errors++;
            $display("no checkpoint restore was exercised");
        end
        $display("errors %0d, stall cycles %0d, restores %0d", errors, stall_cycles, restores);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        watchdog = 0;
        while (watchdog < CYCLE_LIMIT) begin
            @(posedge clk);
            watchdog++;
        end
        $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/rename_pkg.sv
hw/rename_ctrl.sv
hw/map_table.sv
hw/free_list.sv
hw/checkpoint_store.sv
hw/rename_top.sv
testbench/rename_tb.sv

//--- Bender.yml
package:
  name: rename_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/rename_pkg.sv
      - hw/rename_ctrl.sv
      - hw/map_table.sv
      - hw/free_list.sv
      - hw/checkpoint_store.sv
      - hw/rename_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/rename_tb.sv
